// File: hw/bootSoc_settings.svh
`ifndef BOOTSOC_SETTINGS_SVH
`define BOOTSOC_SETTINGS_SVH

// Cycles the loader idles after reset before touching storage
`define BOOT_RESET_CYCLES 32

// Program RAM geometry, 32-bit words
`define RAM_WORDS 1024
`define RAM_ADDR_BITS 10

// Framebuffer geometry, one byte per pixel
`define FB_WIDTH 256
`define FB_HEIGHT 256

`endif

// File: hw/bootPkg.sv
`include "bootSoc_settings.svh"

package bootPkg;

    typedef logic [31:0] word_t;

    typedef logic [`RAM_ADDR_BITS-1:0] ramAddr_t;

    // Request to the block-storage word reader
    typedef struct packed {
        logic  read;
        word_t addr;
    } storeReq_t;

    // Busy level plus the word it returns
    typedef struct packed {
        logic  busy;
        word_t data;
    } storeRsp_t;

    // One image word on its way from fetch to write
    typedef struct packed {
        logic     valid;
        ramAddr_t addr;
        word_t    data;
    } bootWord_t;

    // Program RAM write port
    typedef struct packed {
        logic     writeEn;
        ramAddr_t addr;
        word_t    data;
    } ramWrite_t;

endpackage

// File: hw/busPkg.sv
`include "bootSoc_settings.svh"

package busPkg;

    localparam int pixelXBits = $clog2(`FB_WIDTH);
    localparam int pixelYBits = $clog2(`FB_HEIGHT);

    // Processor data bus
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] writeData;
        logic        write;
        logic        read;
    } cpuBus_t;

    typedef logic [7:0] pixel_t;

    // Y sits above X so the struct lines up with address bits 31:16
    typedef struct packed {
        logic [pixelYBits-1:0] y;
        logic [pixelXBits-1:0] x;
    } pixelAddr_t;

    typedef struct packed {
        logic       write;
        pixelAddr_t addr;
        pixel_t     color;
    } pixelWrite_t;

endpackage

// File: hw/bootFetch.sv
`include "bootSoc_settings.svh"

module bootFetch (
    input  logic               clk_25mhz,
    input  logic               rstN,
    output bootPkg::storeReq_t storeReq,
    input  bootPkg::storeRsp_t storeRsp,
    output bootPkg::bootWord_t fetched,
    output logic               lastWord
);
    import bootPkg::*;

    typedef enum logic [2:0] {
        sResetWait,
        sLenPulse,
        sLenBusy,
        sWordPulse,
        sWordBusy,
        sDone
    } fetchState_t;

    fetchState_t state;
    word_t       waitCount;
    word_t       remaining;
    ramAddr_t    ramIndex;

    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            state         <= sResetWait;
            waitCount     <= '0;
            remaining     <= '0;
            ramIndex      <= '0;
            storeReq.read <= 1'b0;
            fetched.valid <= 1'b0;
            lastWord      <= 1'b0;
        end else begin
            // Strobes are single-cycle unless a state sets them again
            storeReq.read <= 1'b0;
            fetched.valid <= 1'b0;
            lastWord      <= 1'b0;

            case (state)
                sResetWait: begin
                    waitCount <= waitCount + 1'b1;
                    if (waitCount == `BOOT_RESET_CYCLES - 1) begin
                        // Word 0 holds the image length
                        storeReq.read <= 1'b1;
                        storeReq.addr <= '0;
                        state         <= sLenPulse;
                    end
                end

                // Busy is guaranteed up by the cycle after the pulse
                sLenPulse: begin
                    state <= sLenBusy;
                end

                sLenBusy: begin
                    if (!storeRsp.busy) begin
                        remaining <= storeRsp.data;
                        if (storeRsp.data == '0) begin
                            // Empty image, signal completion without a word
                            lastWord <= 1'b1;
                            state    <= sDone;
                        end else begin
                            storeReq.read <= 1'b1;
                            storeReq.addr <= 32'd1;
                            state         <= sWordPulse;
                        end
                    end
                end

                sWordPulse: begin
                    state <= sWordBusy;
                end

                sWordBusy: begin
                    if (!storeRsp.busy) begin
                        fetched.valid <= 1'b1;
                        fetched.addr  <= ramIndex;
                        fetched.data  <= storeRsp.data;
                        ramIndex      <= ramIndex + 1'b1;
                        remaining     <= remaining - 1'b1;
                        if (remaining == 32'd1) begin
                            lastWord <= 1'b1;
                            state    <= sDone;
                        end else begin
                            // Next read goes out while write stage commits this one
                            storeReq.read <= 1'b1;
                            storeReq.addr <= storeReq.addr + 1'b1;
                            state         <= sWordPulse;
                        end
                    end
                end

                // Loader stays parked until the next reset
                sDone: begin
                    state <= sDone;
                end

                default: begin
                    state <= sResetWait;
                end
            endcase
        end
    end

endmodule

// File: hw/bootWrite.sv
module bootWrite (
    input  logic               clk_25mhz,
    input  logic               rstN,
    input  bootPkg::bootWord_t fetched,
    input  logic               lastWord,
    output bootPkg::ramWrite_t ramWr,
    output logic               bootDone
);

    // Set while the RAM write of the final word is on the port
    logic lastWrite;

    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            ramWr.writeEn <= 1'b0;
            lastWrite     <= 1'b0;
            bootDone      <= 1'b0;
        end else begin
            ramWr.writeEn <= fetched.valid;
            lastWrite     <= fetched.valid && lastWord;

            // Zero-length image finishes without any write
            if (lastWrite || (lastWord && !fetched.valid)) begin
                bootDone <= 1'b1;
            end
        end
    end

    // Address and data follow the valid, no reset needed
    always_ff @(posedge clk_25mhz) begin
        if (fetched.valid) begin
            ramWr.addr <= fetched.addr;
            ramWr.data <= fetched.data;
        end
    end

endmodule

// File: hw/wordRam.sv
module wordRam #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 1024
) (
    input  logic                     clk_25mhz,
    input  logic                     writeEn,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 writeData,
    output payload_t                 readData
);

    payload_t mem [DEPTH];

    // Read returns the old contents when a write hits the same address
    always_ff @(posedge clk_25mhz) begin
        if (writeEn) begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr];
    end

endmodule

// File: hw/busDecode.sv
`include "bootSoc_settings.svh"

module busDecode (
    input  logic                clk_25mhz,
    input  logic                rstN,
    input  logic                bootDone,
    input  bootPkg::ramWrite_t  ramWr,
    input  busPkg::cpuBus_t     cpuBus,
    output logic                ramWriteEn,
    output bootPkg::ramAddr_t   ramAddr,
    output bootPkg::word_t      ramWriteData,
    input  bootPkg::word_t      ramReadData,
    output bootPkg::word_t      cpuReadData,
    output busPkg::pixelWrite_t pixelWr,
    input  busPkg::pixelAddr_t  videoAddr,
    output busPkg::pixelAddr_t  fbAddr
);
    import busPkg::*;

    logic ramSel;
    logic fbSel;
    logic ramReadLast;

    // Upper half zero is program RAM, lower half zero with upper set is the framebuffer
    assign ramSel = (cpuBus.addr[31:16] == 16'h0000);
    assign fbSel  = (cpuBus.addr[15:0] == 16'h0000) && !ramSel;

    // Loader owns the RAM port until boot is complete
    always_comb begin
        if (bootDone) begin
            ramWriteEn   = cpuBus.write && ramSel;
            ramAddr      = cpuBus.addr[`RAM_ADDR_BITS-1:0];
            ramWriteData = cpuBus.writeData;
        end else begin
            ramWriteEn   = ramWr.writeEn;
            ramAddr      = ramWr.addr;
            ramWriteData = ramWr.data;
        end
    end

    // Pixel coordinates come straight from address bits 31:16
    assign pixelWr.write = bootDone && cpuBus.write && fbSel;
    assign pixelWr.addr  = pixelAddr_t'(cpuBus.addr[31:16]);
    assign pixelWr.color = pixel_t'(cpuBus.writeData[7:0]);

    // Write takes the framebuffer port, video scan otherwise
    assign fbAddr = pixelWr.write ? pixelWr.addr : videoAddr;

    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            ramReadLast <= 1'b0;
        end else begin
            ramReadLast <= bootDone && cpuBus.read && ramSel;
        end
    end

    // Registered RAM output lines up with the strobe one cycle back
    assign cpuReadData = ramReadLast ? ramReadData : '0;

endmodule

// File: hw/bootSoc.sv
`include "bootSoc_settings.svh"

module bootSoc (
    input  logic               clk_25mhz,
    input  logic               rstN,
    output bootPkg::storeReq_t storeReq,
    input  bootPkg::storeRsp_t storeRsp,
    input  busPkg::cpuBus_t    cpuBus,
    output bootPkg::word_t     cpuReadData,
    input  busPkg::pixelAddr_t videoAddr,
    output busPkg::pixel_t     videoPixel,
    output logic               cpuRunning
);
    import bootPkg::*;
    import busPkg::*;

    bootWord_t   fetched;
    logic        lastWord;
    ramWrite_t   ramWr;
    logic        bootDone;
    logic        ramWriteEn;
    ramAddr_t    ramAddr;
    word_t       ramWriteData;
    word_t       ramReadData;
    pixelWrite_t pixelWr;
    pixelAddr_t  fbAddr;

    bootFetch fetchStage (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN),
        .storeReq  (storeReq),
        .storeRsp  (storeRsp),
        .fetched   (fetched),
        .lastWord  (lastWord)
    );

    bootWrite writeStage (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN),
        .fetched   (fetched),
        .lastWord  (lastWord),
        .ramWr     (ramWr),
        .bootDone  (bootDone)
    );

    busDecode decoder (
        .clk_25mhz    (clk_25mhz),
        .rstN         (rstN),
        .bootDone     (bootDone),
        .ramWr        (ramWr),
        .cpuBus       (cpuBus),
        .ramWriteEn   (ramWriteEn),
        .ramAddr      (ramAddr),
        .ramWriteData (ramWriteData),
        .ramReadData  (ramReadData),
        .cpuReadData  (cpuReadData),
        .pixelWr      (pixelWr),
        .videoAddr    (videoAddr),
        .fbAddr       (fbAddr)
    );

    wordRam #(
        .payload_t (word_t),
        .DEPTH     (`RAM_WORDS)
    ) programRam (
        .clk_25mhz (clk_25mhz),
        .writeEn   (ramWriteEn),
        .addr      (ramAddr),
        .writeData (ramWriteData),
        .readData  (ramReadData)
    );

    // Video scan shares the single port with processor pixel writes
    wordRam #(
        .payload_t (pixel_t),
        .DEPTH     (`FB_WIDTH * `FB_HEIGHT)
    ) frameBuffer (
        .clk_25mhz (clk_25mhz),
        .writeEn   (pixelWr.write),
        .addr      (fbAddr),
        .writeData (pixelWr.color),
        .readData  (videoPixel)
    );

    // Processor is held until the image is in RAM
    assign cpuRunning = bootDone;

endmodule

// File: verification/clockGen.sv
module clockGen (
    output logic clk_25mhz,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfPeriod  = 20;
    localparam int resetCycles = 10;

    initial begin
        clk_25mhz = 1'b0;
        forever #halfPeriod clk_25mhz = ~clk_25mhz;
    end

    // Reset released on a rising edge like every other input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk_25mhz);
        rstN <= 1'b1;
    end

endmodule

// File: verification/bootSoc_chk.sv
module bootSoc_chk (
    input logic               clk_25mhz,
    input logic               rstN,
    input bootPkg::storeReq_t storeReq,
    input bootPkg::storeRsp_t storeRsp,
    input bootPkg::bootWord_t fetched,
    input logic               lastWord
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failCount = 0;
    logic lastSeen;

    // Remembers that the final word has gone out
    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            lastSeen <= 1'b0;
        end else if (lastWord) begin
            lastSeen <= 1'b1;
        end
    end

    readPulseWidth: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        storeReq.read |=> !storeReq.read)
    else begin
        $error("storage read pulse lasted more than one cycle");
        failCount++;
    end

    // Busy low, and not the cycle right after it fell
    readWhileIdle: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        storeReq.read |-> !storeRsp.busy && !$fell(storeRsp.busy))
    else begin
        $error("storage read pulse issued while the reader was busy");
        failCount++;
    end

    noWordAfterLast: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        lastSeen |-> !fetched.valid)
    else begin
        $error("fetched word valid after the last word");
        failCount++;
    end

endmodule

bind bootFetch bootSoc_chk fetchChk (.*);

// File: verification/bootSocTb.sv
`include "bootSoc_settings.svh"

module bootSocTb;
    timeunit 1ns;
    timeprecision 1ps;
    import bootPkg::*;
    import busPkg::*;

    localparam string inputPath = "verification/bootSoc_input.txt";
    localparam int    fileWords = 256;

    logic       clk_25mhz;
    logic       rstN;
    storeReq_t  storeReq;
    storeRsp_t  storeRsp = '0;
    cpuBus_t    cpuBus = '0;
    word_t      cpuReadData;
    pixelAddr_t videoAddr = '0;
    pixel_t     videoPixel;
    logic       cpuRunning;

    word_t  fileData [fileWords];
    int     imageWords;
    int     opCount;
    int     opBase;
    logic   loaded = 1'b0;
    integer seed = 32'h9c86;

    // Storage model and boot monitor state
    int    busyLeft = 0;
    word_t pendingAddr;
    int    readsDone = 0;
    int    pulsesSeen = 0;
    int    cyclesOutOfReset = 0;
    logic  runSeen = 1'b0;

    clockGen clocks (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN)
    );

    bootSoc uut (
        .clk_25mhz   (clk_25mhz),
        .rstN        (rstN),
        .storeReq    (storeReq),
        .storeRsp    (storeRsp),
        .cpuBus      (cpuBus),
        .cpuReadData (cpuReadData),
        .videoAddr   (videoAddr),
        .videoPixel  (videoPixel),
        .cpuRunning  (cpuRunning)
    );

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string testName, input word_t expected, input word_t actual);
        assert (actual === expected)
        else stopRun($sformatf("Error: %s expected %h actual %h", testName, expected, actual));
    endtask

    task automatic issueWrite(input word_t addr, input word_t data);
        @(posedge clk_25mhz);
        cpuBus.write     <= 1'b1;
        cpuBus.addr      <= addr;
        cpuBus.writeData <= data;
        @(posedge clk_25mhz);
        cpuBus.write     <= 1'b0;
    endtask

    task automatic ramRead(input string testName, input word_t addr, input word_t expected);
        @(posedge clk_25mhz);
        cpuBus.read <= 1'b1;
        cpuBus.addr <= addr;
        @(posedge clk_25mhz);
        cpuBus.read <= 1'b0;
        @(posedge clk_25mhz);
        checkWord(testName, expected, cpuReadData);
    endtask

    // X from address bits 23:16, Y from bits 31:24
    task automatic pixelRead(input string testName, input word_t addr, input word_t expected);
        @(posedge clk_25mhz);
        videoAddr.x <= addr[23:16];
        videoAddr.y <= addr[31:24];
        @(posedge clk_25mhz);
        @(posedge clk_25mhz);
        checkWord(testName, expected, word_t'(videoPixel));
    endtask

    // One read per cycle, data compared two edges after its address
    task automatic readBackImage();
        int i;
        for (i = 0; i <= imageWords + 1; i++) begin
            @(posedge clk_25mhz);
            if (i < imageWords) begin
                cpuBus.read <= 1'b1;
                cpuBus.addr <= word_t'(i);
            end else begin
                cpuBus.read <= 1'b0;
            end
            if (i >= 2) begin
                checkWord($sformatf("ramReadback[%0d]", i - 2), fileData[i - 1], cpuReadData);
            end
        end
    endtask

    task automatic runOps(input bit duringBoot);
        int    j;
        word_t code;
        word_t addr;
        word_t data;
        word_t expected;
        string testName;
        for (j = 0; j < opCount; j++) begin
            code     = fileData[opBase + 4 * j];
            addr     = fileData[opBase + 4 * j + 1];
            data     = fileData[opBase + 4 * j + 2];
            expected = fileData[opBase + 4 * j + 3];
            testName = $sformatf("op%0d", j);
            if (duringBoot) begin
                if (code == 5) begin
                    assert (!cpuRunning) else stopRun("Boot finished before the early writes");
                    issueWrite(addr, data);
                end
            end else begin
                case (code)
                    1: ramRead(testName, addr, expected);
                    2: issueWrite(addr, data);
                    3: pixelRead(testName, addr, expected);
                    4: issueWrite(addr, data);
                    5: begin
                        // Already issued while booting
                    end
                    default: stopRun($sformatf("Unknown operation code %h in input file", code));
                endcase
            end
        end
    endtask

    // Block-storage reader with random latency
    always @(posedge clk_25mhz) begin
        if (!rstN) begin
            storeRsp  <= '0;
            readsDone <= 0;
            busyLeft  = 0;
        end else if (storeReq.read) begin
            pendingAddr = storeReq.addr;
            busyLeft    = ($unsigned($random(seed)) % 8) + 1;
            storeRsp.busy <= 1'b1;
        end else if (storeRsp.busy) begin
            if (busyLeft == 1) begin
                storeRsp.busy <= 1'b0;
                storeRsp.data <= fileData[pendingAddr];
                readsDone     <= readsDone + 1;
            end
            busyLeft = busyLeft - 1;
        end
    end

    // Boot sequencing as seen from outside
    always @(posedge clk_25mhz) begin
        if (!rstN) begin
            cyclesOutOfReset = 0;
        end else begin
            cyclesOutOfReset++;
            if (storeReq.read) begin
                assert (cyclesOutOfReset > `BOOT_RESET_CYCLES)
                else stopRun("Storage read issued inside the reset wait");
                assert (!cpuRunning) else stopRun("Storage read issued after cpuRunning rose");
                pulsesSeen++;
            end
            if (cpuRunning) begin
                assert (readsDone == imageWords + 1)
                else stopRun("cpuRunning rose before every storage read had completed");
                runSeen = 1'b1;
            end else begin
                assert (!runSeen) else stopRun("cpuRunning fell after boot");
            end
            assert (uut.fetchStage.fetchChk.failCount == 0)
            else stopRun("A bound loader assertion failed");
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (imageWords + 1) * 12 + opCount * 4 + 200;
        repeat (limit) @(posedge clk_25mhz);
        $display("Watchdog expired after %0d cycles without the test finishing", limit);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        $readmemh(inputPath, fileData);
        assert (!$isunknown(fileData[0])) else stopRun("Input file could not be read");
        imageWords = fileData[0];
        opCount    = fileData[imageWords + 1];
        opBase     = imageWords + 2;
        loaded     = 1'b1;

        // Early writes go out after the loader has filled their addresses
        while (readsDone < imageWords) @(posedge clk_25mhz);
        runOps(1'b1);
        while (!cpuRunning) @(posedge clk_25mhz);
        readBackImage();
        runOps(1'b0);

        assert (pulsesSeen == imageWords + 1)
        else stopRun($sformatf("Error: storageReads expected %0d actual %0d",
                               imageWords + 1, pulsesSeen));
        if (uut.fetchStage.fetchChk.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Bound loader assertions reported a failure");
            $display("TEST FAILED");
            $fatal(1, "loader assertion failure");
        end
    end

endmodule

// File: bootSoc.f
+incdir+hw
hw/bootPkg.sv
hw/busPkg.sv
hw/bootFetch.sv
hw/bootWrite.sv
hw/wordRam.sv
hw/busDecode.sv
hw/bootSoc.sv
verification/clockGen.sv
verification/bootSoc_chk.sv
verification/bootSocTb.sv

// File: verification/bootSoc_input.txt
// Image: word count N, then N program words
// Ops: op count, then per op: code address data expected
// Codes: 1 RAM read, 2 pixel write, 3 pixel read, 4 RAM write, 5 write during boot
00000008
deadbeef 12345678 cafef00d 0badc0de
a5a5a5a5 5a5a5a5a 00000001 80000000
0000000f
// Writes during boot must be ignored
00000005 00000002 ffffffff 00000000
00000005 00000005 00000000 00000000
00000001 00000002 00000000 cafef00d
// Index above RAM depth wraps to 5
00000001 00000405 00000000 5a5a5a5a
// Pixels at y 0x12, x 0x34 and x 0x35
00000002 12340000 ffffff33 00000000
00000002 12350000 00000044 00000000
00000003 12340000 00000000 00000033
00000003 12350000 00000000 00000044
00000002 12340000 000000c7 00000000
00000003 12340000 00000000 000000c7
00000003 12350000 00000000 00000044
// RAM write after boot leaves the framebuffer alone
00000004 00000003 76543210 00000000
00000001 00000003 00000000 76543210
00000001 00000004 00000000 a5a5a5a5
00000003 12340000 00000000 000000c7
